/* rewardPkg.sv */
`default_nettype none

package rewardPkg;

    // header field width, every word of a packet uses it
    localparam int WORD_WIDTH = 16;

    // invitations stop rippling at this distance from the cluster head
    localparam logic [WORD_WIDTH-1:0] MAX_INV_HOPS = 16'd4;

    // special addresses
    localparam logic [WORD_WIDTH-1:0] BROADCAST_ID = '1;
    localparam logic [WORD_WIDTH-1:0] SINK_ID      = '0;

    // filler for header fields a packet kind leaves unused
    localparam logic [WORD_WIDTH-1:0] INVALID_WORD = '1;

    // packet kinds as they appear on air
    typedef enum logic [2:0] {
        HB      = 3'd0,
        CHE     = 3'd1,
        INV     = 3'd2,
        MR      = 3'd3,
        CHT     = 3'd4,
        DATA    = 3'd5,
        SOS     = 3'd6,
        INVALID = 3'd7
    } pktTypeE;

    // node's own view of itself and its cluster
    typedef struct packed {
        logic [WORD_WIDTH-1:0] myNodeId;
        logic [WORD_WIDTH-1:0] myEnergy;
        logic [WORD_WIDTH-1:0] myQValue;
        logic [WORD_WIDTH-1:0] hopsFromSink;
        logic [WORD_WIDTH-1:0] hopsFromCh;
        logic [WORD_WIDTH-1:0] chosenCh;
        // next hop towards the sink
        logic [WORD_WIDTH-1:0] chosenHop;
        logic [WORD_WIDTH-1:0] timeslot;
        logic                  isClusterHead;
        logic                  lowEnergy;
    } nodeInfoT;

    // header of the last packet heard, already filtered upstream
    typedef struct packed {
        pktTypeE               packetType;
        logic [WORD_WIDTH-1:0] sourceId;
        logic [WORD_WIDTH-1:0] sourceHops;
        logic [WORD_WIDTH-1:0] qValue;
        logic [WORD_WIDTH-1:0] energyLeft;
        logic [WORD_WIDTH-1:0] hopsFromCh;
        logic [WORD_WIDTH-1:0] chosenCh;
    } rxPacketT;

    // request inputs frozen at capture
    typedef struct packed {
        nodeInfoT node;
        rxPacketT rx;
        logic     iHaveData;
        logic     iAmDestination;
    } reqCaptureT;

    // outgoing header handed to the radio
    typedef struct packed {
        pktTypeE               packetType;
        logic [WORD_WIDTH-1:0] sourceId;
        logic [WORD_WIDTH-1:0] sourceHops;
        logic [WORD_WIDTH-1:0] qValue;
        logic [WORD_WIDTH-1:0] energyLeft;
        logic [WORD_WIDTH-1:0] hopsFromCh;
        logic [WORD_WIDTH-1:0] chosenCh;
        logic [WORD_WIDTH-1:0] destId;
        logic [WORD_WIDTH-1:0] timeslot;
        // high selects the far (multi-hop) power setting
        logic                  txFar;
    } txPacketT;

endpackage

`default_nettype wire

/* rewardCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module rewardCtrl import rewardPkg::*; (
    input  logic    clk,
    input  logic    nrst,
    input  logic    en,
    input  logic    timerExpired,
    input  logic    okToSend,
    input  pktTypeE selType,
    output logic    capture,
    output logic    isIdle,
    output logic    txValid,
    output logic    rewardDone,
    output logic    hbLock
);

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        PROCESS = 2'd1,
        DONE    = 2'd2
    } stateE;

    stateE state;
    stateE nextState;
    logic  transfer;

    assign isIdle  = (state == IDLE);
    // request seen in idle, either from outside or from the timer
    assign capture = isIdle && (en || timerExpired);
    // header is waiting for the radio for as long as we sit in done
    assign txValid = (state == DONE);
    // radio takes the header on this edge
    assign transfer = txValid && okToSend;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (capture) begin
                    nextState = PROCESS;
                end
            end
            PROCESS: begin
                // nothing to send, go straight back
                if (selType == INVALID) begin
                    nextState = IDLE;
                end else begin
                    nextState = DONE;
                end
            end
            DONE: begin
                // hold here under back-pressure
                if (okToSend) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // one-cycle completion pulse, lands together with the return to idle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rewardDone <= 1'b0;
        end else begin
            rewardDone <= transfer;
        end
    end

    // heartbeat lock, set once an HB ripple goes out
    // a transferred data packet opens it again
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hbLock <= 1'b0;
        end else if (transfer) begin
            if (selType == HB) begin
                hbLock <= 1'b1;
            end else if (selType == DATA) begin
                hbLock <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* clusterTimer.sv */
`timescale 1ns/1ps
`default_nettype none

module clusterTimer #(
    parameter int TIMEOUT_RELOAD = 10
) (
    input  logic clk,
    input  logic nrst,
    input  logic isIdle,
    input  logic en,
    input  logic hbLock,
    output logic timerExpired
);

    localparam int CNT_WIDTH = $clog2(TIMEOUT_RELOAD + 1);
    localparam logic [CNT_WIDTH-1:0] RELOAD_VAL = CNT_WIDTH'(TIMEOUT_RELOAD);

    logic [CNT_WIDTH-1:0] count;
    logic                 counting;

    // only wait for cluster formation once a heartbeat has gone out
    // and nothing else is asking for the block
    assign counting     = isIdle && !en && hbLock;
    assign timerExpired = counting && (count == '0);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= RELOAD_VAL;
        end else if (counting) begin
            // expiry reloads on the same edge the request is taken
            if (count == '0) begin
                count <= RELOAD_VAL;
            end else begin
                count <= count - 1'b1;
            end
        end else if (isIdle) begin
            // en or an open lock restarts the wait
            count <= RELOAD_VAL;
        end
        // outside idle the count holds
    end

endmodule

`default_nettype wire

/* packetSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module packetSelect import rewardPkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       capture,
    input  logic       timerExpired,
    input  logic       hbLock,
    input  logic       iHaveData,
    input  logic       iAmDestination,
    input  nodeInfoT   node,
    input  rxPacketT   rx,
    output pktTypeE    selType,
    output reqCaptureT captured
);

    pktTypeE nextType;
    logic    rxHb;
    logic    rxInvRipple;
    logic    dataReq;

    assign rxHb        = (rx.packetType == HB) && !hbLock;
    assign rxInvRipple = (rx.packetType == INV) && (rx.hopsFromCh < MAX_INV_HOPS);
    // forwarded data addressed to us, or our own data
    assign dataReq     = ((rx.packetType == DATA) && iAmDestination) || iHaveData;

    // first match wins
    always_comb begin
        if (rxHb) begin
            nextType = HB;
        end else if (rxInvRipple) begin
            nextType = INV;
        end else if (timerExpired && !node.isClusterHead) begin
            // member gave up waiting for invitations
            nextType = MR;
        end else if (timerExpired && node.isClusterHead) begin
            // head done collecting membership requests
            nextType = CHT;
        end else if (node.isClusterHead && hbLock) begin
            // head advertises itself
            nextType = INV;
        end else if (dataReq) begin
            nextType = node.lowEnergy ? SOS : DATA;
        end else begin
            nextType = INVALID;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            selType <= INVALID;
        end else if (capture) begin
            selType <= nextType;
        end
    end

    // frozen request for the packer
    always_ff @(posedge clk) begin
        if (capture) begin
            captured.node           <= node;
            captured.rx             <= rx;
            captured.iHaveData      <= iHaveData;
            captured.iAmDestination <= iAmDestination;
        end
    end

endmodule

`default_nettype wire

/* packetPack.sv */
`timescale 1ns/1ps
`default_nettype none

module packetPack import rewardPkg::*; (
    input  logic       clk,
    input  logic       nrst,
    input  logic       capture,
    input  pktTypeE    selType,
    input  reqCaptureT captured,
    output txPacketT   tx
);

    txPacketT nextTx;
    logic     loadTx;
    logic     invRipple;
    logic     ownData;

    // ripple if the frozen rx invite is still in range, else our own
    assign invRipple = (captured.rx.packetType == INV) &&
                       (captured.rx.hopsFromCh < MAX_INV_HOPS);
    assign ownData   = captured.iHaveData;

    always_comb begin
        // unused fields stay all-ones
        nextTx.packetType = selType;
        nextTx.sourceId   = INVALID_WORD;
        nextTx.sourceHops = INVALID_WORD;
        nextTx.qValue     = INVALID_WORD;
        nextTx.energyLeft = INVALID_WORD;
        nextTx.hopsFromCh = INVALID_WORD;
        nextTx.chosenCh   = INVALID_WORD;
        nextTx.destId     = BROADCAST_ID;
        nextTx.timeslot   = captured.node.timeslot;
        nextTx.txFar      = 1'b0;

        case (selType)
            HB: begin
                nextTx.sourceId   = captured.rx.sourceId;
                nextTx.sourceHops = captured.node.hopsFromSink + WORD_WIDTH'(1);
                nextTx.qValue     = captured.rx.qValue;
                nextTx.energyLeft = captured.node.myEnergy;
                nextTx.chosenCh   = '0;
            end
            INV: begin
                if (invRipple) begin
                    nextTx.sourceId   = captured.rx.sourceId;
                    nextTx.sourceHops = captured.node.hopsFromCh;
                    nextTx.qValue     = captured.rx.qValue;
                    nextTx.energyLeft = captured.rx.energyLeft;
                    nextTx.hopsFromCh = captured.rx.hopsFromCh + WORD_WIDTH'(1);
                    nextTx.chosenCh   = '0;
                end else begin
                    // head's own invitation, one hop from itself
                    nextTx.sourceId   = captured.node.myNodeId;
                    nextTx.sourceHops = captured.node.hopsFromSink;
                    nextTx.qValue     = captured.node.myQValue;
                    nextTx.energyLeft = captured.node.myEnergy;
                    nextTx.hopsFromCh = WORD_WIDTH'(1);
                    nextTx.chosenCh   = captured.node.myNodeId;
                end
            end
            MR: begin
                nextTx.sourceId   = captured.node.myNodeId;
                nextTx.sourceHops = captured.node.hopsFromSink;
                nextTx.qValue     = captured.node.myQValue;
                nextTx.energyLeft = captured.node.myEnergy;
                nextTx.hopsFromCh = captured.node.hopsFromCh;
                nextTx.chosenCh   = captured.node.chosenCh;
                nextTx.destId     = captured.node.chosenCh;
                // head out of one-hop reach needs the far setting
                nextTx.txFar      = (captured.node.hopsFromCh > WORD_WIDTH'(1));
            end
            CHT: begin
                nextTx.sourceId   = captured.node.myNodeId;
                nextTx.sourceHops = captured.node.hopsFromSink;
                nextTx.qValue     = captured.node.myQValue;
                nextTx.energyLeft = captured.node.myEnergy;
                nextTx.hopsFromCh = '0;
                nextTx.chosenCh   = captured.node.myNodeId;
            end
            DATA, SOS: begin
                if (ownData) begin
                    nextTx.sourceId   = captured.node.myNodeId;
                    nextTx.sourceHops = captured.node.hopsFromSink;
                    nextTx.qValue     = captured.node.myQValue;
                    nextTx.energyLeft = captured.node.myEnergy;
                    nextTx.hopsFromCh = captured.node.hopsFromCh;
                    nextTx.chosenCh   = captured.node.chosenCh;
                end else begin
                    // forwarding, keep the originator's header
                    nextTx.sourceId   = captured.rx.sourceId;
                    nextTx.sourceHops = captured.rx.sourceHops;
                    nextTx.qValue     = captured.rx.qValue;
                    nextTx.energyLeft = captured.rx.energyLeft;
                    nextTx.hopsFromCh = captured.rx.hopsFromCh;
                    nextTx.chosenCh   = captured.rx.chosenCh;
                end
                // next to the sink goes straight to it
                if (captured.node.hopsFromSink == WORD_WIDTH'(1)) begin
                    nextTx.destId = SINK_ID;
                end else begin
                    nextTx.destId = captured.node.chosenHop;
                end
            end
            default: begin
                nextTx.packetType = INVALID;
                nextTx.destId     = INVALID_WORD;
            end
        endcase
    end

    // load one cycle after capture, tx then holds until the next request
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            loadTx <= 1'b0;
        end else begin
            loadTx <= capture;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            tx.packetType <= INVALID;
            tx.sourceId   <= INVALID_WORD;
            tx.sourceHops <= INVALID_WORD;
            tx.qValue     <= INVALID_WORD;
            tx.energyLeft <= INVALID_WORD;
            tx.hopsFromCh <= INVALID_WORD;
            tx.chosenCh   <= INVALID_WORD;
            tx.destId     <= INVALID_WORD;
            tx.timeslot   <= INVALID_WORD;
            tx.txFar      <= 1'b0;
        end else if (loadTx) begin
            tx <= nextTx;
        end
    end

endmodule

`default_nettype wire

/* rewardTop.sv */
`timescale 1ns/1ps
`default_nettype none

module rewardTop import rewardPkg::*; #(
    parameter int TIMEOUT_RELOAD = 10
) (
    input  logic     clk,
    input  logic     nrst,
    input  logic     en,
    input  logic     okToSend,
    input  logic     iHaveData,
    input  logic     iAmDestination,
    input  nodeInfoT node,
    input  rxPacketT rx,
    output txPacketT tx,
    output logic     txValid,
    output logic     rewardDone
);

    logic       capture;
    logic       isIdle;
    logic       timerExpired;
    logic       hbLock;
    pktTypeE    selType;
    reqCaptureT captured;

    // sequencer, lock and handshake
    rewardCtrl rewardCtrl_inst (
        .clk          (clk),
        .nrst         (nrst),
        .en           (en),
        .timerExpired (timerExpired),
        .okToSend     (okToSend),
        .selType      (selType),
        .capture      (capture),
        .isIdle       (isIdle),
        .txValid      (txValid),
        .rewardDone   (rewardDone),
        .hbLock       (hbLock)
    );

    // cluster formation wait
    clusterTimer #(
        .TIMEOUT_RELOAD (TIMEOUT_RELOAD)
    ) clusterTimer_inst (
        .clk          (clk),
        .nrst         (nrst),
        .isIdle       (isIdle),
        .en           (en),
        .hbLock       (hbLock),
        .timerExpired (timerExpired)
    );

    // packet kind decision
    packetSelect packetSelect_inst (
        .clk            (clk),
        .nrst           (nrst),
        .capture        (capture),
        .timerExpired   (timerExpired),
        .hbLock         (hbLock),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .node           (node),
        .rx             (rx),
        .selType        (selType),
        .captured       (captured)
    );

    // header fields and power setting
    packetPack packetPack_inst (
        .clk      (clk),
        .nrst     (nrst),
        .capture  (capture),
        .selType  (selType),
        .captured (captured),
        .tx       (tx)
    );

endmodule

`default_nettype wire

/* tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held over the first few rising edges
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

`default_nettype wire

/* rewardTop_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module rewardTop_assertions import rewardPkg::*; (
    input logic     clk,
    input logic     nrst,
    input logic     okToSend,
    input logic     txValid,
    input logic     rewardDone,
    input txPacketT tx
);

    // read by the testbench summary
    int failCount = 0;

    // completion pulse only right after a transfer edge
    doneAfterTransfer: assert property (@(posedge clk) disable iff (!nrst)
        rewardDone |-> $past(txValid && okToSend))
        else begin
            $error("rewardDone without a transfer on the previous edge");
            failCount++;
        end

    // header frozen under back-pressure
    txStable: assert property (@(posedge clk) disable iff (!nrst)
        (txValid && !okToSend) |=> $stable(tx))
        else begin
            $error("tx changed while waiting for okToSend");
            failCount++;
        end

    validType: assert property (@(posedge clk) disable iff (!nrst)
        txValid |-> (tx.packetType != INVALID))
        else begin
            $error("txValid with packet type INVALID");
            failCount++;
        end

endmodule

bind rewardTop rewardTop_assertions rewardTop_assertions_inst (
    .clk        (clk),
    .nrst       (nrst),
    .okToSend   (okToSend),
    .txValid    (txValid),
    .rewardDone (rewardDone),
    .tx         (tx)
);

`default_nettype wire

/* rewardTb.sv */
`timescale 1ns/1ps
`default_nettype none

module rewardTb import rewardPkg::*; ();

    localparam int TIMEOUT_RELOAD = 12;
    localparam int NUM_ROWS       = 14;
    localparam int TIMER_ROWS     = 3;
    localparam int MAX_DELAY      = 3;
    localparam int CYCLE_LIMIT    = NUM_ROWS * (4 + MAX_DELAY)
                                  + TIMER_ROWS * (TIMEOUT_RELOAD + 2) + 50;

    // one table entry with request, trigger and expected header
    typedef struct packed {
        nodeInfoT node;
        rxPacketT rx;
        logic     iHaveData;
        logic     iAmDestination;
        logic     useTimer;
        logic     expectPkt;
        txPacketT exp;
    } rowT;

    logic     clk;
    logic     nrst;
    logic     en;
    logic     okToSend;
    logic     iHaveData;
    logic     iAmDestination;
    nodeInfoT node;
    rxPacketT rx;
    txPacketT tx;
    logic     txValid;
    logic     rewardDone;

    rowT         rows [NUM_ROWS];
    int          rowCount  = 0;
    int          errCount  = 0;
    int          rowErrs   = 0;
    int          passRows  = 0;
    int          cycles    = 0;
    logic [31:0] rndState  = 32'h34765a58;

    tbClock #(.PERIOD(40), .RESET_CYCLES(3)) tbClock_inst (.clk(clk), .nrst(nrst));

    rewardTop #(.TIMEOUT_RELOAD(TIMEOUT_RELOAD)) rewardTop_inst (
        .clk            (clk),
        .nrst           (nrst),
        .en             (en),
        .okToSend       (okToSend),
        .iHaveData      (iHaveData),
        .iAmDestination (iAmDestination),
        .node           (node),
        .rx             (rx),
        .tx             (tx),
        .txValid        (txValid),
        .rewardDone     (rewardDone)
    );

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic nodeInfoT nodeFields(logic [15:0] id, logic [15:0] energy,
                                            logic [15:0] q, logic [15:0] hSink,
                                            logic [15:0] hCh, logic [15:0] ch,
                                            logic [15:0] hop, logic [15:0] ts,
                                            logic isCh, logic low);
        nodeInfoT n;
        n = '{id, energy, q, hSink, hCh, ch, hop, ts, isCh, low};
        return n;
    endfunction

    function automatic rxPacketT rxFields(pktTypeE t, logic [15:0] src, logic [15:0] hops,
                                          logic [15:0] q, logic [15:0] energy,
                                          logic [15:0] hCh, logic [15:0] ch);
        rxPacketT r;
        r = '{t, src, hops, q, energy, hCh, ch};
        return r;
    endfunction

    function automatic txPacketT txFields(pktTypeE t, logic [15:0] src, logic [15:0] hops,
                                          logic [15:0] q, logic [15:0] energy,
                                          logic [15:0] hCh, logic [15:0] ch,
                                          logic [15:0] dest, logic [15:0] ts, logic far);
        txPacketT p;
        p = '{t, src, hops, q, energy, hCh, ch, dest, ts, far};
        return p;
    endfunction

    task automatic addRow(nodeInfoT n, rxPacketT r, logic own, logic dest,
                          logic useTimer, logic expectPkt, txPacketT e);
        rows[rowCount] = '{n, r, own, dest, useTimer, expectPkt, e};
        rowCount++;
    endtask

    task automatic checkWord(string name, logic [15:0] got, logic [15:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            rowErrs++;
        end
    endtask

    task automatic failNote(string what);
        $display("row failure at %0t ns: %s", $time, what);
        rowErrs++;
    endtask

    task automatic checkHeader(txPacketT e);
        checkWord("tx.packetType", 16'(tx.packetType), 16'(e.packetType));
        checkWord("tx.sourceId", tx.sourceId, e.sourceId);
        checkWord("tx.sourceHops", tx.sourceHops, e.sourceHops);
        checkWord("tx.qValue", tx.qValue, e.qValue);
        checkWord("tx.energyLeft", tx.energyLeft, e.energyLeft);
        checkWord("tx.hopsFromCh", tx.hopsFromCh, e.hopsFromCh);
        checkWord("tx.chosenCh", tx.chosenCh, e.chosenCh);
        checkWord("tx.destId", tx.destId, e.destId);
        checkWord("tx.timeslot", tx.timeslot, e.timeslot);
        checkWord("tx.txFar", 16'(tx.txFar), 16'(e.txFar));
    endtask

    task automatic buildTable();
        nodeInfoT nA;
        nodeInfoT nHead;
        nodeInfoT nFar;
        nodeInfoT nNear;
        nodeInfoT nSink;
        nodeInfoT nLow;
        rxPacketT rxHb;
        rxPacketT rxIdle;
        rxPacketT rxData;
        txPacketT none;
        nA    = nodeFields(16'h0011, 16'h0300, 16'h0050, 2, 2, 16'h0021, 16'h0031, 5, 0, 0);
        nHead = nodeFields(16'h0044, 16'h0400, 16'h0060, 3, 0, 16'h0044, 16'h0032, 7, 1, 0);
        nFar  = nodeFields(16'h0012, 16'h0280, 16'h0052, 4, 3, 16'h0022, 16'h0033, 9, 0, 0);
        nNear = nodeFields(16'h0013, 16'h0290, 16'h0053, 2, 1, 16'h0023, 16'h0034, 10, 0, 0);
        nSink = nodeFields(16'h0015, 16'h0310, 16'h0055, 1, 2, 16'h0025, 16'h0035, 11, 0, 0);
        nLow  = nodeFields(16'h0016, 16'h0020, 16'h0056, 3, 2, 16'h0026, 16'h0036, 12, 0, 1);
        rxHb   = rxFields(HB, 16'h0101, 1, 16'h0070, 16'h0200, 16'hffff, 0);
        rxIdle = rxFields(CHE, 16'h0105, 2, 16'h0075, 16'h0205, 2, 16'h0029);
        rxData = rxFields(DATA, 16'h0201, 4, 16'h0081, 16'h0150, 1, 16'h0027);
        none   = txFields(INVALID, 0, 0, 0, 0, 0, 0, 0, 0, 0);
        // heartbeat ripple then locked
        addRow(nA, rxHb, 0, 0, 0, 1,
               txFields(HB, 16'h0101, 3, 16'h0070, 16'h0300, 16'hffff, 0, 16'hffff, 5, 0));
        addRow(nA, rxHb, 0, 0, 0, 0, none);
        // invitations in range, out of range and the head's own
        addRow(nA, rxFields(INV, 16'h0102, 5, 16'h0071, 16'h0210, 3, 16'h0021), 0, 0, 0, 1,
               txFields(INV, 16'h0102, 2, 16'h0071, 16'h0210, 4, 0, 16'hffff, 5, 0));
        addRow(nA, rxFields(INV, 16'h0103, 6, 16'h0072, 16'h0220, 4, 16'h0021),
               0, 0, 0, 0, none);
        addRow(nHead, rxIdle, 0, 0, 0, 1,
               txFields(INV, 16'h0044, 3, 16'h0060, 16'h0400, 1, 16'h0044, 16'hffff, 7, 0));
        // timer driven rows
        addRow(nFar, rxIdle, 0, 0, 1, 1,
               txFields(MR, 16'h0012, 4, 16'h0052, 16'h0280, 3, 16'h0022, 16'h0022, 9, 1));
        addRow(nNear, rxIdle, 0, 0, 1, 1,
               txFields(MR, 16'h0013, 2, 16'h0053, 16'h0290, 1, 16'h0023, 16'h0023, 10, 0));
        addRow(nHead, rxIdle, 0, 0, 1, 1,
               txFields(CHT, 16'h0044, 3, 16'h0060, 16'h0400, 0, 16'h0044, 16'hffff, 7, 0));
        // own data next to the sink opens the lock
        addRow(nSink, rxIdle, 1, 0, 0, 1,
               txFields(DATA, 16'h0015, 1, 16'h0055, 16'h0310, 2, 16'h0025, 16'h0000, 11, 0));
        addRow(nA, rxHb, 0, 0, 0, 1,
               txFields(HB, 16'h0101, 3, 16'h0070, 16'h0300, 16'hffff, 0, 16'hffff, 5, 0));
        // low energy turns data into SOS
        addRow(nLow, rxData, 0, 1, 0, 1,
               txFields(SOS, 16'h0201, 4, 16'h0081, 16'h0150, 1, 16'h0027, 16'h0036, 12, 0));
        addRow(nLow, rxIdle, 1, 0, 0, 1,
               txFields(SOS, 16'h0016, 3, 16'h0056, 16'h0020, 2, 16'h0026, 16'h0036, 12, 0));
        addRow(nA, rxData, 0, 1, 0, 1,
               txFields(DATA, 16'h0201, 4, 16'h0081, 16'h0150, 1, 16'h0027, 16'h0031, 5, 0));
        addRow(nA, rxHb, 0, 0, 0, 1,
               txFields(HB, 16'h0101, 3, 16'h0070, 16'h0300, 16'hffff, 0, 16'hffff, 5, 0));
    endtask

    task automatic runRow(int idx);
        rowT      r;
        int       delay;
        int       waited;
        r = rows[idx];
        rowErrs = 0;
        @(posedge clk);
        node           <= r.node;
        rx             <= r.rx;
        iHaveData      <= r.iHaveData;
        iAmDestination <= r.iAmDestination;
        okToSend       <= 1'b0;
        en             <= !r.useTimer;
        if (!r.useTimer) begin
            // capture edge
            @(posedge clk);
            en <= 1'b0;
            @(negedge clk);
            checkWord("txValid", 16'(txValid), 16'd0);
            @(negedge clk);
            if (r.expectPkt) begin
                checkWord("txValid", 16'(txValid), 16'd1);
            end else begin
                repeat (4) begin
                    checkWord("txValid", 16'(txValid), 16'd0);
                    @(negedge clk);
                end
            end
        end else begin
            waited = 0;
            @(negedge clk);
            while (txValid !== 1'b1 && waited < TIMEOUT_RELOAD + 6) begin
                @(negedge clk);
                waited++;
            end
            assert (txValid === 1'b1) else failNote("timer never produced a packet");
        end
        if (r.expectPkt && txValid === 1'b1) begin
            checkHeader(r.exp);
            rndState = xorshift(rndState);
            delay = int'(rndState % (MAX_DELAY + 1));
            // header must sit still under back-pressure
            repeat (delay) begin
                @(negedge clk);
                checkWord("txValid", 16'(txValid), 16'd1);
                checkHeader(r.exp);
            end
            @(posedge clk);
            okToSend <= 1'b1;
            // transfer edge
            @(posedge clk);
            okToSend <= 1'b0;
            @(negedge clk);
            checkWord("rewardDone", 16'(rewardDone), 16'd1);
            checkWord("txValid", 16'(txValid), 16'd0);
            @(negedge clk);
            checkWord("rewardDone", 16'(rewardDone), 16'd0);
        end
        errCount += rowErrs;
        if (rowErrs == 0) begin
            passRows++;
        end
        $display("row %0d: %s, %0d errors", idx, (rowErrs == 0) ? "passed" : "failed", rowErrs);
    endtask

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int asrtFails;
        en             = 1'b0;
        okToSend       = 1'b0;
        iHaveData      = 1'b0;
        iAmDestination = 1'b0;
        node           = '0;
        rx             = '0;
        buildTable();
        @(posedge nrst);
        @(negedge clk);
        // reset values
        checkWord("txValid", 16'(txValid), 16'd0);
        checkWord("rewardDone", 16'(rewardDone), 16'd0);
        checkWord("tx.packetType", 16'(tx.packetType), 16'(INVALID));
        $display("reset: %s, %0d errors", (rowErrs == 0) ? "passed" : "failed", rowErrs);
        errCount += rowErrs;
        rowErrs = 0;
        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end
        asrtFails = rewardTop_inst.rewardTop_assertions_inst.failCount;
        $display("rows %0d, passed %0d, check errors %0d, assertion failures %0d",
                 rowCount, passRows, errCount, asrtFails);
        if (errCount == 0 && asrtFails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rewardPkg.sv
rewardCtrl.sv
clusterTimer.sv
packetSelect.sv
packetPack.sv
rewardTop.sv
tbClock.sv
rewardTop_assertions.sv
rewardTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module rewardTb -o rewardSim

./obj_dir/rewardSim +verilator+error+limit+1000 | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
